//--- common/mont_defines.svh
`ifndef MONT_DEFINES_SVH
`define MONT_DEFINES_SVH

// operand width N
`define MONT_WIDTH 1024

// accumulator width, room for sums up to 8m
`define MONT_ACC_WIDTH (`MONT_WIDTH + 4)

// radix-4, two bits of a per iteration
`define MONT_DIGIT_WIDTH 2

// one iteration per digit of a
`define MONT_ITERATIONS (`MONT_WIDTH / 2)

// counts 0 .. MONT_ITERATIONS-1
`define MONT_CNT_WIDTH 10

`endif

//--- common/mont_pkg.sv
`default_nettype none

package mont_pkg;

`include "mont_defines.svh"

    // plain operand word, a, b, m and the result
    typedef logic [`MONT_WIDTH-1:0] operand_t;

    // accumulator word, wide enough for acc + 3b + 3m
    typedef logic [`MONT_ACC_WIDTH-1:0] acc_t;

    // precomputed multiples, built once per multiplication
    typedef struct packed {
        acc_t b1;
        acc_t b2;
        acc_t b3;
        acc_t m1;
        acc_t m2;
        acc_t m3;
    } multiples_t;

    // sequencer states
    typedef enum logic [2:0] {
        st_idle,    // waiting for start
        st_load,    // operands captured, building multiples
        st_prep,    // accumulator cleared
        st_iterate, // one radix-4 step per cycle
        st_reduce   // final conditional subtraction
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- operand_loader/operand_loader.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module operand_loader (
    input  wire logic                   clk,
    input  wire logic                   resetn,
    input  wire logic                   capture, // latch a, b, m
    input  wire logic                   prep,    // build multiples, load a shifter
    input  wire logic                   step,    // consume one digit of a
    input  mont_pkg::operand_t          a,
    input  mont_pkg::operand_t          b,
    input  mont_pkg::operand_t          m,
    output mont_pkg::multiples_t        mults,
    output logic [`MONT_DIGIT_WIDTH-1:0] a_digit
);
    import mont_pkg::*;

    localparam int pad_w = `MONT_ACC_WIDTH - `MONT_WIDTH;

    operand_t a_q;   // captured operands
    operand_t b_q;
    operand_t m_q;
    operand_t a_sr;  // a, shifted down one digit per step
    acc_t     b_ext;
    acc_t     m_ext;

    // zero-extend to accumulator width
    function automatic acc_t widen(operand_t x);
        return {{pad_w{1'b0}}, x};
    endfunction

    assign b_ext = widen(b_q);
    assign m_ext = widen(m_q);

    // operand capture on the start edge
    always_ff @(posedge clk) begin
        if (capture) begin
            a_q <= a;
            b_q <= b;
            m_q <= m;
        end
    end

    // multiples table, one registered cycle
    always_ff @(posedge clk) begin
        if (prep) begin
            mults.b1 <= b_ext;
            mults.b2 <= b_ext << 1;
            mults.b3 <= b_ext + (b_ext << 1); // 3b < 2^1026
            mults.m1 <= m_ext;
            mults.m2 <= m_ext << 1;
            mults.m3 <= m_ext + (m_ext << 1);
        end
    end

    // digit shifter for a, lsb digit first
    always_ff @(posedge clk) begin
        if (prep) begin
            a_sr <= a_q;
        end else if (step) begin
            a_sr <= {{`MONT_DIGIT_WIDTH{1'b0}}, a_sr[`MONT_WIDTH-1:`MONT_DIGIT_WIDTH]};
        end
    end

    assign a_digit = a_sr[`MONT_DIGIT_WIDTH-1:0];

    // quotient digit choice relies on m^-1 = m mod 4, needs odd m
    a_m_odd: assert property (@(posedge clk) disable iff (!resetn)
        prep |-> m_q[0]);

endmodule

`default_nettype wire

//--- montgomery_core/mont_controller.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module mont_controller (
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic start,
    output logic      capture,
    output logic      prep,
    output logic      clear,
    output logic      step,
    output logic      reduce
);
    import mont_pkg::*;

    ctrl_state_t                state;
    ctrl_state_t                state_next;
    logic [`MONT_CNT_WIDTH-1:0] cnt;       // iterations done so far
    logic                       last_step;

    assign last_step = (cnt == `MONT_CNT_WIDTH'(`MONT_ITERATIONS - 1));

    always_comb begin
        state_next = state;
        case (state)
            st_idle:    if (start) state_next = st_load; // busy starts are dropped
            st_load:    state_next = st_prep;
            st_prep:    state_next = st_iterate;
            st_iterate: if (last_step) state_next = st_reduce;
            st_reduce:  state_next = st_idle;
            default:    state_next = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
            cnt   <= '0;
        end else begin
            state <= state_next;
            if (state == st_iterate) begin
                cnt <= cnt + `MONT_CNT_WIDTH'(1);
            end else begin
                cnt <= '0; // ready for the next run
            end
        end
    end

    // strobes straight from the state
    assign capture = (state == st_idle) && start; // sample on the start edge
    assign prep    = (state == st_load);
    assign clear   = (state == st_prep);
    assign step    = (state == st_iterate);
    assign reduce  = (state == st_reduce);

    // steps form one unbroken run that opens right after the clear cycle
    a_step_window: assert property (@(posedge clk) disable iff (!resetn)
        step |-> $past(step || clear));

endmodule

`default_nettype wire

//--- montgomery_core/mont_datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module mont_datapath (
    input  wire logic                         clk,
    input  wire logic                         resetn,
    input  wire logic                         clear,   // acc back to zero
    input  wire logic                         step,    // one radix-4 iteration
    input  wire logic [`MONT_DIGIT_WIDTH-1:0] a_digit,
    input  mont_pkg::multiples_t              mults,
    output mont_pkg::acc_t                    acc
);
    import mont_pkg::*;

    acc_t                         b_sel;   // a_digit * b
    acc_t                         m_sel;   // q_digit * m
    acc_t                         sum_b;   // acc + a_digit*b
    acc_t                         sum_m;   // ... + q_digit*m, divisible by 4
    logic [`MONT_DIGIT_WIDTH-1:0] q_digit;

    // first add, multiple of b picked by the digit of a
    always_comb begin
        case (a_digit)
            2'd0: b_sel = '0;
            2'd1: b_sel = mults.b1;
            2'd2: b_sel = mults.b2;
            2'd3: b_sel = mults.b3;
            default: b_sel = '0;
        endcase
    end

    assign sum_b = acc + b_sel; // < 5m

    // q = -sum * m^-1 mod 4
    // odd m is its own inverse mod 4, so m[1:0] serves as m^-1
    assign q_digit = (2'd0 - sum_b[1:0]) * mults.m1[1:0];

    // second add, multiple of m that clears the low digit
    always_comb begin
        case (q_digit)
            2'd0: m_sel = '0;
            2'd1: m_sel = mults.m1;
            2'd2: m_sel = mults.m2;
            2'd3: m_sel = mults.m3;
            default: m_sel = '0;
        endcase
    end

    assign sum_m = sum_b + m_sel; // < 8m, fits in N+4 bits

    always_ff @(posedge clk) begin
        if (clear) begin
            acc <= '0;
        end else if (step) begin
            // exact divide by 4
            acc <= {{`MONT_DIGIT_WIDTH{1'b0}},
                    sum_m[`MONT_ACC_WIDTH-1:`MONT_DIGIT_WIDTH]};
        end
    end

    // digit dropped by the shift must be zero, else the result is off by 2^-2k
    a_low_digit_zero: assert property (@(posedge clk) disable iff (!resetn)
        step |-> (sum_m[`MONT_DIGIT_WIDTH-1:0] == '0));

    // loop invariant acc < 2m, which lets one subtraction finish the job
    a_acc_bound: assert property (@(posedge clk) disable iff (!resetn)
        step |=> (acc < (mults.m1 << 1)));

endmodule

`default_nettype wire

//--- source/final_reduce.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module final_reduce (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire logic          reduce, // acc holds the loop result
    input  mont_pkg::acc_t     acc,    // < 2m
    input  mont_pkg::operand_t m,
    output mont_pkg::operand_t result,
    output logic               done
);
    import mont_pkg::*;

    localparam int pad_w = `MONT_ACC_WIDTH - `MONT_WIDTH;

    acc_t diff;   // acc - m, wraps when acc < m
    logic borrow;

    assign diff   = acc - {{pad_w{1'b0}}, m};
    assign borrow = diff[`MONT_ACC_WIDTH-1]; // acc < 2^(N+1), so msb means negative

    // result holds until the next reduce
    always_ff @(posedge clk) begin
        if (reduce) begin
            result <= borrow ? acc[`MONT_WIDTH-1:0] : diff[`MONT_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            done <= 1'b0;
        end else begin
            done <= reduce; // single pulse, reduce lasts one cycle
        end
    end

    // fully reduced output, m still the captured modulus
    a_result_reduced: assert property (@(posedge clk) disable iff (!resetn)
        done |-> (result < m));

endmodule

`default_nettype wire

//--- source/mont_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module mont_top (
    input  wire logic          clk,
    input  wire logic          resetn,
    input  wire logic          start,  // one-cycle strobe, sampled in idle only
    input  mont_pkg::operand_t a,
    input  mont_pkg::operand_t b,
    input  mont_pkg::operand_t m,      // odd modulus
    output mont_pkg::operand_t result, // a*b*2^-N mod m
    output logic               done    // one-cycle strobe
);
    import mont_pkg::*;

    // strobes from the sequencer
    logic capture;
    logic prep;
    logic clear;
    logic step;
    logic reduce;

    multiples_t                   mults;   // b1..b3, m1..m3
    logic [`MONT_DIGIT_WIDTH-1:0] a_digit; // current digit of a
    acc_t                         acc;

    mont_controller u_controller (
        .clk     (clk),
        .resetn  (resetn),
        .start   (start),
        .capture (capture),
        .prep    (prep),
        .clear   (clear),
        .step    (step),
        .reduce  (reduce)
    );

    operand_loader u_loader (
        .clk     (clk),
        .resetn  (resetn),
        .capture (capture),
        .prep    (prep),
        .step    (step),
        .a       (a),
        .b       (b),
        .m       (m),
        .mults   (mults),
        .a_digit (a_digit)
    );

    mont_datapath u_datapath (
        .clk     (clk),
        .resetn  (resetn),
        .clear   (clear),
        .step    (step),
        .a_digit (a_digit),
        .mults   (mults),
        .acc     (acc)
    );

    // captured m, low N bits of m1
    final_reduce u_reduce (
        .clk     (clk),
        .resetn  (resetn),
        .reduce  (reduce),
        .acc     (acc),
        .m       (mults.m1[`MONT_WIDTH-1:0]),
        .result  (result),
        .done    (done)
    );

endmodule

`default_nettype wire

//--- verification/tb_mont_ref.svh
`ifndef TB_MONT_REF_SVH
`define TB_MONT_REF_SVH

// bit-serial montgomery product a*b*2^-N mod m, needs odd m and a, b < m
function automatic mont_pkg::operand_t mont_ref(input mont_pkg::operand_t a,
                                                input mont_pkg::operand_t b,
                                                input mont_pkg::operand_t m);
    logic [`MONT_WIDTH+1:0] s; // stays below 2m, worst case 4m before the halving
    s = '0;
    for (int i = 0; i < `MONT_WIDTH; i++) begin
        if (a[i]) begin
            s = s + {2'b00, b};
        end
        if (s[0]) begin
            s = s + {2'b00, m}; // odd sum, add m to make it even
        end
        s = s >> 1;
    end
    if (s >= {2'b00, m}) begin
        s = s - {2'b00, m}; // one subtraction is enough
    end
    return s[`MONT_WIDTH-1:0];
endfunction

// full-width random word, 32 bits at a time
function automatic mont_pkg::operand_t rand_operand();
    mont_pkg::operand_t v;
    for (int i = 0; i < `MONT_WIDTH / 32; i++) begin
        v[i*32 +: 32] = $urandom();
    end
    return v;
endfunction

// odd modulus
function automatic mont_pkg::operand_t rand_modulus();
    mont_pkg::operand_t v;
    v = rand_operand();
    v[0] = 1'b1;
    return v;
endfunction

// random operand already reduced mod m
function automatic mont_pkg::operand_t rand_below(input mont_pkg::operand_t m);
    return rand_operand() % m;
endfunction

`endif

//--- verification/tb_mont_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "mont_defines.svh"

module tb_mont_top;
    import mont_pkg::*;

`include "tb_mont_ref.svh"

    localparam int latency     = `MONT_ITERATIONS + 3; // start edge to done edge
    localparam int n_runs      = 14;                   // start strobes issued, dropped one too
    localparam int cycle_limit = n_runs * latency + 200;

    logic     clk;
    logic     resetn;
    logic     start;
    operand_t a;
    operand_t b;
    operand_t m;
    operand_t result;
    logic     done;

    int cycle        = 0;
    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int done_seen    = 0; // done pulses observed so far
    int test_err0    = 0;
    bit done_prev    = 1'b0;

    operand_t exp_q[$];   // expected results, oldest first
    int       start_q[$]; // cycle of each accepted start edge

    mont_top DUT (
        .clk    (clk),
        .resetn (resetn),
        .start  (start),
        .a      (a),
        .b      (b),
        .m      (m),
        .result (result),
        .done   (done)
    );

    always #5 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= cycle_limit) begin
            $display("timeout: no finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    // every done against the oldest outstanding expectation
    initial begin
        operand_t exp_r;
        int       lat;
        forever begin
            @(posedge clk);
            #1;
            if (done) begin
                checks += 2;
                assert (!done_prev) else begin
                    $display("done stayed high for more than one cycle at cycle %0d", cycle);
                    errors++;
                end
                assert (exp_q.size() > 0) else begin
                    $display("done pulsed with no multiplication in flight at cycle %0d", cycle);
                    errors++;
                end
                if (exp_q.size() > 0) begin
                    exp_r = exp_q.pop_front();
                    lat   = cycle - start_q.pop_front();
                    checks += 2;
                    assert (result == exp_r) else begin
                        $display("Mismatch result: expected %h, actual %h", exp_r, result);
                        errors++;
                    end
                    assert (lat == latency) else begin
                        $display("Mismatch done latency: expected %h, actual %h", latency, lat);
                        errors++;
                    end
                end
                done_seen++;
            end
            done_prev = done;
        end
    end

    // one-cycle start, called 1 ns after an edge, returns 1 ns after the next
    task automatic pulse_start(input operand_t a_in, input operand_t b_in, input operand_t m_in);
        a     = a_in;
        b     = b_in;
        m     = m_in;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic launch_mult(input operand_t a_in, input operand_t b_in, input operand_t m_in);
        exp_q.push_back(mont_ref(a_in, b_in, m_in));
        pulse_start(a_in, b_in, m_in);
        start_q.push_back(cycle); // edge that sampled start
    endtask

    // checker counts on the edge, poll on the falling edge
    task automatic wait_done(input int seen0);
        while (done_seen == seen0) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_mult(input operand_t a_in, input operand_t b_in, input operand_t m_in);
        int seen0;
        seen0 = done_seen;
        launch_mult(a_in, b_in, m_in);
        wait_done(seen0);
    endtask

    task automatic mark_test_start();
        test_err0 = errors;
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (errors == test_err0) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", tests_run, name, errors - test_err0);
        end
    endtask

    initial begin
        operand_t m_r;
        operand_t a_r;
        operand_t b_r;
        int       seen0;
        clk    = 1'b0;
        resetn = 1'b0;
        start  = 1'b0;
        a      = '0;
        b      = '0;
        m      = '0;
        void'($urandom(32'h588f_6820)); // single seed for the whole run

        repeat (10) @(posedge clk);
        #1;
        resetn = 1'b1;

        // 1: quiet idle
        mark_test_start();
        repeat (20) begin
            @(posedge clk);
            #1;
            checks++;
            assert (!done) else begin
                $display("done went high while idle at cycle %0d", cycle);
                errors++;
            end
        end
        report_test("idle after reset");

        // 2: zero operand, then 2^-N mod m
        mark_test_start();
        m_r = rand_modulus();
        run_mult('0, rand_below(m_r), m_r);
        run_mult(operand_t'(1), operand_t'(1), m_r);
        report_test("directed operands");

        // 3: random moduli and operands
        mark_test_start();
        repeat (8) begin
            m_r = rand_modulus();
            a_r = rand_below(m_r);
            b_r = rand_below(m_r);
            run_mult(a_r, b_r, m_r);
        end
        report_test("random operands");

        // 4: latency checked by the compare process, single pulse checked here
        mark_test_start();
        m_r = rand_modulus();
        run_mult(rand_below(m_r), rand_below(m_r), m_r);
        checks++;
        assert (!done) else begin
            $display("done still high one cycle after its pulse");
            errors++;
        end
        report_test("done timing");

        // 5: second start mid-run must be dropped
        mark_test_start();
        m_r   = rand_modulus();
        seen0 = done_seen;
        launch_mult(rand_below(m_r), rand_below(m_r), m_r);
        repeat (`MONT_ITERATIONS / 2) @(posedge clk);
        #1;
        m_r = rand_modulus();
        pulse_start(rand_below(m_r), rand_below(m_r), m_r); // no expectation queued
        wait_done(seen0);
        repeat (latency) @(posedge clk); // a second run would have finished by now
        #1;
        checks++;
        assert (done_seen == seen0 + 1) else begin
            $display("start while busy was not ignored, %0d done pulses", done_seen - seen0);
            errors++;
        end
        report_test("start while busy");

        // 6: largest modulus, needs the final subtraction
        mark_test_start();
        m_r = '1;
        a_r = m_r - operand_t'(1);
        run_mult(a_r, a_r, m_r);
        report_test("final subtraction");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- mont_top.f
+incdir+common
+incdir+verification
common/mont_pkg.sv
operand_loader/operand_loader.sv
montgomery_core/mont_controller.sv
montgomery_core/mont_datapath.sv
source/final_reduce.sv
source/mont_top.sv
verification/tb_mont_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs tb_mont_top with Verilator; exit status 0 only on a passing run.

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_mont_top \
    -f mont_top.f \
    --Mdir "$build_dir" -o vsim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/vsim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^>>> PASS$' "$log_file"; then
    exit 0
fi

echo "pass message not found in $log_file"
exit 1
